/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_top
FILELIST := all.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := Finished with no errors

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* all.f */
design/arb_pkg.sv
design/mem_pkg.sv
design/first_set_finder.sv
design/rr_arbiter.sv
design/apb_client_port.sv
design/bus_switch.sv
design/shared_ram.sv
design/apb_shared_ram_top.sv
test/arb_sva.sv
test/tb_top.sv

/* design/apb_client_port.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_client_port
    import mem_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst_n,
    // APB completer side
    input  logic     i_psel,
    input  logic     i_penable,
    input  logic     i_pwrite,
    input  addr_t    i_paddr,
    input  data_t    i_pwdata,
    output data_t    o_prdata,
    output logic     o_pready,
    output logic     o_pslverr,
    // towards the arbiter and the switch
    output logic     o_req,
    output mem_req_t o_mem_req,
    input  logic     i_rsp_valid,
    input  mem_rsp_t i_rsp
);

    // an access is waiting for its RAM result
    logic     r_pending;
    logic     w_capture;
    mem_req_t w_live_req;
    // captured copy of the transfer, held until the response
    mem_req_t r_mem_req;

    // take the transfer in its first access-phase cycle only; the pready
    // cycle still shows psel and penable and must not start a new request
    assign w_capture = i_psel && i_penable && !r_pending && !o_pready;

    assign w_live_req = '{write: i_pwrite, addr: i_paddr, wdata: i_pwdata};

    // the request is visible in the capture cycle itself so the arbiter
    // can grant one cycle later
    assign o_req     = r_pending || w_capture;
    assign o_mem_req = r_pending ? r_mem_req : w_live_req;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_pending <= 1'b0;
            o_pready  <= 1'b0;
        end else begin
            // pready follows the response strobe by exactly one cycle
            o_pready <= i_rsp_valid;
            if (i_rsp_valid) begin
                r_pending <= 1'b0;
            end else if (w_capture) begin
                r_pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (w_capture) begin
            r_mem_req <= w_live_req;
        end
        // result registers, sampled by the master together with pready
        if (i_rsp_valid) begin
            o_prdata  <= i_rsp.rdata;
            o_pslverr <= i_rsp.err;
        end
    end

endmodule : apb_client_port

`default_nettype wire

/* design/apb_shared_ram_top.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_shared_ram_top
    import arb_pkg::*, mem_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_rst_n,
    // port 0
    input  logic  i_psel_0,
    input  logic  i_penable_0,
    input  logic  i_pwrite_0,
    input  addr_t i_paddr_0,
    input  data_t i_pwdata_0,
    output data_t o_prdata_0,
    output logic  o_pready_0,
    output logic  o_pslverr_0,
    // port 1
    input  logic  i_psel_1,
    input  logic  i_penable_1,
    input  logic  i_pwrite_1,
    input  addr_t i_paddr_1,
    input  data_t i_pwdata_1,
    output data_t o_prdata_1,
    output logic  o_pready_1,
    output logic  o_pslverr_1,
    // port 2
    input  logic  i_psel_2,
    input  logic  i_penable_2,
    input  logic  i_pwrite_2,
    input  addr_t i_paddr_2,
    input  data_t i_pwdata_2,
    output data_t o_prdata_2,
    output logic  o_pready_2,
    output logic  o_pslverr_2
);

    // ==========================================================
    // interconnect between ports, arbiter, switch and RAM
    // ==========================================================

    port_vec_t port_req;
    mem_req_t  port_mem_req [NUM_PORTS];
    port_vec_t port_rsp_valid;
    mem_rsp_t  sw_rsp;
    logic      gnt_valid;
    port_vec_t gnt;
    port_id_t  gnt_id;
    port_vec_t gnt_ack;
    logic      arb_block;
    logic      ram_req_valid;
    mem_req_t  ram_req;
    logic      ram_rsp_valid;
    mem_rsp_t  ram_rsp;

    apb_client_port u_port_0 (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_psel      (i_psel_0),
        .i_penable   (i_penable_0),
        .i_pwrite    (i_pwrite_0),
        .i_paddr     (i_paddr_0),
        .i_pwdata    (i_pwdata_0),
        .o_prdata    (o_prdata_0),
        .o_pready    (o_pready_0),
        .o_pslverr   (o_pslverr_0),
        .o_req       (port_req[0]),
        .o_mem_req   (port_mem_req[0]),
        .i_rsp_valid (port_rsp_valid[0]),
        .i_rsp       (sw_rsp)
    );

    apb_client_port u_port_1 (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_psel      (i_psel_1),
        .i_penable   (i_penable_1),
        .i_pwrite    (i_pwrite_1),
        .i_paddr     (i_paddr_1),
        .i_pwdata    (i_pwdata_1),
        .o_prdata    (o_prdata_1),
        .o_pready    (o_pready_1),
        .o_pslverr   (o_pslverr_1),
        .o_req       (port_req[1]),
        .o_mem_req   (port_mem_req[1]),
        .i_rsp_valid (port_rsp_valid[1]),
        .i_rsp       (sw_rsp)
    );

    apb_client_port u_port_2 (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_psel      (i_psel_2),
        .i_penable   (i_penable_2),
        .i_pwrite    (i_pwrite_2),
        .i_paddr     (i_paddr_2),
        .i_pwdata    (i_pwdata_2),
        .o_prdata    (o_prdata_2),
        .o_pready    (o_pready_2),
        .o_pslverr   (o_pslverr_2),
        .o_req       (port_req[2]),
        .o_mem_req   (port_mem_req[2]),
        .i_rsp_valid (port_rsp_valid[2]),
        .i_rsp       (sw_rsp)
    );

    rr_arbiter #(
        .CLIENTS (NUM_PORTS)
    ) u_arbiter (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_block     (arb_block),
        .i_req       (port_req),
        .i_gnt_ack   (gnt_ack),
        .o_gnt_valid (gnt_valid),
        .o_gnt       (gnt),
        .o_gnt_id    (gnt_id)
    );

    bus_switch u_switch (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_req           (port_req),
        .i_mem_req       (port_mem_req),
        .i_gnt_valid     (gnt_valid),
        .i_gnt           (gnt),
        .i_gnt_id        (gnt_id),
        .o_gnt_ack       (gnt_ack),
        .o_block         (arb_block),
        .o_ram_req_valid (ram_req_valid),
        .o_ram_req       (ram_req),
        .i_ram_rsp_valid (ram_rsp_valid),
        .i_ram_rsp       (ram_rsp),
        .o_rsp_valid     (port_rsp_valid),
        .o_rsp           (sw_rsp)
    );

    shared_ram u_ram (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_req_valid (ram_req_valid),
        .i_req       (ram_req),
        .o_rsp_valid (ram_rsp_valid),
        .o_rsp       (ram_rsp)
    );

endmodule : apb_shared_ram_top

`default_nettype wire

/* design/arb_pkg.sv */
`default_nettype none

package arb_pkg;

    // ==========================================================
    // arbitration sizes shared by the arbiter and the switch
    // ==========================================================

    // number of peer requesters sharing the RAM
    localparam int NUM_PORTS = 3;

    // client index, wide enough for every port
    typedef logic [1:0] port_id_t;

    // one bit per port, used for requests, grants and acknowledges
    typedef logic [NUM_PORTS-1:0] port_vec_t;

endpackage : arb_pkg

`default_nettype wire

/* design/bus_switch.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_switch
    import arb_pkg::*, mem_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  port_vec_t i_req,
    input  mem_req_t  i_mem_req [NUM_PORTS],
    input  logic      i_gnt_valid,
    input  port_vec_t i_gnt,
    input  port_id_t  i_gnt_id,
    output port_vec_t o_gnt_ack,
    output logic      o_block,
    output logic      o_ram_req_valid,
    output mem_req_t  o_ram_req,
    input  logic      i_ram_rsp_valid,
    input  mem_rsp_t  i_ram_rsp,
    output port_vec_t o_rsp_valid,
    output mem_rsp_t  o_rsp
);

    sw_state_t r_state;
    // port that owns the access currently in flight
    port_id_t  r_id;
    logic      w_accept;
    logic      w_done;

    // a grant counts only if the granted port still asks; this drops the
    // stale grant formed from requests seen before the last acknowledge
    assign w_accept = (r_state == IDLE) && i_gnt_valid && |(i_gnt & i_req);
    assign w_done   = (r_state == BUSY) && i_ram_rsp_valid;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_state         <= IDLE;
            r_id            <= '0;
            o_ram_req_valid <= 1'b0;
        end else begin
            // RAM strobe goes out in the first BUSY cycle
            o_ram_req_valid <= w_accept;
            if (w_accept) begin
                r_state <= BUSY;
                r_id    <= i_gnt_id;
            end else if (w_done) begin
                r_state <= IDLE;
            end
        end
    end

    // hold the arbiter off for the whole access
    assign o_block   = (r_state == BUSY);
    assign o_ram_req = i_mem_req[r_id];

    // response and acknowledge reach the owning port only
    assign o_rsp_valid = w_done ? (port_vec_t'(1) << r_id) : '0;
    assign o_gnt_ack   = w_done ? (port_vec_t'(1) << r_id) : '0;
    assign o_rsp       = i_ram_rsp;

endmodule : bus_switch

`default_nettype wire

/* design/first_set_finder.sv */
`timescale 1ns/1ps
`default_nettype none

module first_set_finder
    import arb_pkg::*;
(
    input  port_vec_t i_data,
    output port_id_t  o_index,
    output logic      o_valid
);

    // scan from the top down so the lowest set bit is written last
    // and therefore wins
    always_comb begin
        o_index = '0;
        for (int i = NUM_PORTS - 1; i >= 0; i--) begin
            if (i_data[i]) begin
                o_index = port_id_t'(i);
            end
        end
    end

    // the index is only meaningful when at least one bit is set
    assign o_valid = |i_data;

endmodule : first_set_finder

`default_nettype wire

/* design/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    // ==========================================================
    // bus and memory geometry
    // ==========================================================

    localparam int ADDR_W    = 12;
    localparam int DATA_W    = 32;
    localparam int RAM_DEPTH = 256;
    // index bits needed to reach every RAM word
    localparam int RAM_IDX_W = $clog2(RAM_DEPTH);

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;

    // one captured access travelling from a port towards the RAM
    typedef struct packed {
        logic  write;
        addr_t addr;
        data_t wdata;
    } mem_req_t;

    // result returned by the RAM, err marks an out-of-range address
    typedef struct packed {
        data_t rdata;
        logic  err;
    } mem_rsp_t;

    // switch is either free to accept a grant or waiting on the RAM
    typedef enum logic {
        IDLE,
        BUSY
    } sw_state_t;

endpackage : mem_pkg

`default_nettype wire

/* design/rr_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter
    import arb_pkg::*;
#(
    parameter int CLIENTS = 3
) (
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_block,
    input  port_vec_t i_req,
    input  port_vec_t i_gnt_ack,
    output logic      o_gnt_valid,
    output port_vec_t o_gnt,
    output port_id_t  o_gnt_id
);

    // ==========================================================
    // request conditioning
    // ==========================================================

    // clients above the first CLIENTS are never considered
    port_vec_t w_req_live;
    // requests after the block input, zero while an access runs
    port_vec_t w_req_post;
    // requests ranked after the last acknowledged winner
    port_vec_t w_req_masked;
    // requests with the last winner removed when others compete
    port_vec_t w_req_excl;

    // set for the indices above the last acknowledged winner
    port_vec_t r_mask;
    // clear only at the last acknowledged winner
    port_vec_t r_excl;

    port_id_t  w_masked_idx;
    port_id_t  w_excl_idx;
    logic      w_masked_vld;
    logic      w_excl_vld;
    port_id_t  w_winner;
    logic      w_win_vld;

    assign w_req_live   = i_req & port_vec_t'((1 << CLIENTS) - 1);
    assign w_req_post   = i_block ? '0 : w_req_live;
    assign w_req_masked = w_req_post & r_mask;
    // a lone requester may win again even if it won last time
    assign w_req_excl   = ($countones(w_req_post) > 1) ? (w_req_post & r_excl) : w_req_post;

    // one finder for the masked set, one for the wrap-around set
    first_set_finder u_masked_finder (
        .i_data  (w_req_masked),
        .o_index (w_masked_idx),
        .o_valid (w_masked_vld)
    );

    first_set_finder u_excl_finder (
        .i_data  (w_req_excl),
        .o_index (w_excl_idx),
        .o_valid (w_excl_vld)
    );

    // ==========================================================
    // winner selection
    // ==========================================================

    // the masked result keeps the rotation going, otherwise start over
    // from the lowest index
    always_comb begin
        if (w_masked_vld) begin
            w_winner  = w_masked_idx;
            w_win_vld = 1'b1;
        end else begin
            w_winner  = w_excl_idx;
            w_win_vld = w_excl_vld;
        end
    end

    // masks only move when the served client is acknowledged, so a grant
    // that never turned into an access does not cost anyone a turn
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_mask <= '0;
            r_excl <= '1;
        end else if (|i_gnt_ack) begin
            // clients above the acknowledged one get the next turn
            r_mask <= ~(i_gnt_ack | (i_gnt_ack - 1'b1));
            r_excl <= ~i_gnt_ack;
        end
    end

    // grant is rebuilt every cycle from this cycle's requests
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_gnt_valid <= 1'b0;
            o_gnt       <= '0;
            o_gnt_id    <= '0;
        end else if (w_win_vld) begin
            o_gnt_valid <= 1'b1;
            o_gnt       <= port_vec_t'(1) << w_winner;
            o_gnt_id    <= w_winner;
        end else begin
            o_gnt_valid <= 1'b0;
            o_gnt       <= '0;
            o_gnt_id    <= '0;
        end
    end

endmodule : rr_arbiter

`default_nettype wire

/* design/shared_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module shared_ram
    import mem_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_req_valid,
    input  mem_req_t i_req,
    output logic     o_rsp_valid,
    output mem_rsp_t o_rsp
);

    data_t                 mem [RAM_DEPTH];
    logic                  w_in_range;
    logic [RAM_IDX_W-1:0]  w_idx;

    // any set bit above the index field means the word does not exist
    assign w_in_range = (i_req.addr[ADDR_W-1:RAM_IDX_W] == '0);
    assign w_idx      = i_req.addr[RAM_IDX_W-1:0];

    // response strobe trails the request by one cycle
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rsp_valid <= 1'b0;
        end else begin
            o_rsp_valid <= i_req_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_req_valid) begin
            if (i_req.write && w_in_range) begin
                mem[w_idx] <= i_req.wdata;
            end
            // writes and out-of-range reads return zero data
            o_rsp.rdata <= (!i_req.write && w_in_range) ? mem[w_idx] : '0;
            o_rsp.err   <= !w_in_range;
        end
    end

endmodule : shared_ram

`default_nettype wire

/* test/arb_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module arb_sva
    import arb_pkg::*;
(
    input logic      i_clk,
    input logic      i_rst_n,
    input port_vec_t i_req,
    input logic      o_gnt_valid,
    input port_vec_t o_gnt
);

    // count of failed checks on the arbiter outputs
    int fail_count = 0;

    // at most one client holds the grant
    a_gnt_onehot : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $onehot0(o_gnt))
    else begin
        fail_count++;
        $error("grant vector has more than one bit set");
    end

    // the valid flag and the grant vector agree
    a_gnt_valid : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_gnt_valid == (o_gnt != '0))
    else begin
        fail_count++;
        $error("grant valid does not match the grant vector");
    end

    // the grant is registered, so the winner asked one cycle earlier
    a_gnt_requested : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_gnt & ~$past(i_req)) == '0)
    else begin
        fail_count++;
        $error("grant given to a client that did not request");
    end

endmodule : arb_sva

bind rr_arbiter arb_sva u_arb_sva (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_req       (i_req),
    .o_gnt_valid (o_gnt_valid),
    .o_gnt       (o_gnt)
);

`default_nettype wire

/* test/tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top
    import arb_pkg::*, mem_pkg::*;
();

    // ==========================================================
    // constants, DUT signals and the reference model
    // ==========================================================

    // upper bound on access-phase cycles before a transfer is given up
    localparam int TIMEOUT_CYCLES  = 40;
    // one cycle each for request, grant, RAM access, response and pready
    localparam int UNLOADED_CYCLES = 5;

    logic   clk;
    logic   rst_n;
    logic   psel    [NUM_PORTS];
    logic   penable [NUM_PORTS];
    logic   pwrite  [NUM_PORTS];
    addr_t  paddr   [NUM_PORTS];
    data_t  pwdata  [NUM_PORTS];
    data_t  prdata  [NUM_PORTS];
    logic   pready  [NUM_PORTS];
    logic   pslverr [NUM_PORTS];

    // mirror of every in-range word written so far
    data_t  ref_mem [RAM_DEPTH];
    integer seed;
    // port indices in the order their transfers completed
    int     done_order [$];

    apb_shared_ram_top DUT (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_psel_0    (psel[0]),
        .i_penable_0 (penable[0]),
        .i_pwrite_0  (pwrite[0]),
        .i_paddr_0   (paddr[0]),
        .i_pwdata_0  (pwdata[0]),
        .o_prdata_0  (prdata[0]),
        .o_pready_0  (pready[0]),
        .o_pslverr_0 (pslverr[0]),
        .i_psel_1    (psel[1]),
        .i_penable_1 (penable[1]),
        .i_pwrite_1  (pwrite[1]),
        .i_paddr_1   (paddr[1]),
        .i_pwdata_1  (pwdata[1]),
        .o_prdata_1  (prdata[1]),
        .o_pready_1  (pready[1]),
        .o_pslverr_1 (pslverr[1]),
        .i_psel_2    (psel[2]),
        .i_penable_2 (penable[2]),
        .i_pwrite_2  (pwrite[2]),
        .i_paddr_2   (paddr[2]),
        .i_pwdata_2  (pwdata[2]),
        .o_prdata_2  (prdata[2]),
        .o_pready_2  (pready[2]),
        .o_pslverr_2 (pslverr[2])
    );

    // 4 ns period
    always #2 clk = ~clk;

    // ==========================================================
    // helpers and compare tasks
    // ==========================================================

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("error: %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_err(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error: %s expected pslverr %b actual %b", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("error: %s expected %0d actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    // a word exists only below the RAM depth
    function automatic logic in_range(input addr_t addr);
        return int'(addr) < RAM_DEPTH;
    endfunction

    function automatic data_t rand_word();
        return $random(seed);
    endfunction

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    // ==========================================================
    // APB driver entered 1 ns after a rising edge
    // ==========================================================

    task automatic apb_xfer(input int p, input logic wr, input addr_t addr,
                            input data_t wdata, output data_t rdata,
                            output logic err, output int cycles);
        // setup phase
        psel[p]    = 1'b1;
        penable[p] = 1'b0;
        pwrite[p]  = wr;
        paddr[p]   = addr;
        pwdata[p]  = wdata;
        @(posedge clk);
        #1;
        // first access-phase cycle
        penable[p] = 1'b1;
        cycles     = 1;
        while (pready[p] !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (pready[p] !== 1'b1) begin
            $display("timeout: port %0d got no pready within %0d access cycles",
                     p, TIMEOUT_CYCLES);
            abort_run();
        end else begin
            rdata = prdata[p];
            err   = pslverr[p];
            done_order.push_back(p);
            // the transfer ends at this edge and a following call may start its setup at once
            @(posedge clk);
            #1;
            psel[p]    = 1'b0;
            penable[p] = 1'b0;
        end
    endtask

    task automatic apb_write(input int p, input addr_t addr, input data_t data,
                             input string name);
        data_t rdata;
        logic  err;
        int    cycles;
        apb_xfer(p, 1'b1, addr, data, rdata, err, cycles);
        check_err(name, !in_range(addr), err);
        // writes past the end change nothing
        if (in_range(addr)) begin
            ref_mem[int'(addr)] = data;
        end
    endtask

    task automatic apb_read(input int p, input addr_t addr, input string name,
                            output int cycles);
        data_t rdata;
        logic  err;
        data_t exp;
        apb_xfer(p, 1'b0, addr, '0, rdata, err, cycles);
        if (in_range(addr)) begin
            exp = ref_mem[int'(addr)];
        end else begin
            exp = '0;
        end
        check_data(name, exp, rdata);
        check_err(name, !in_range(addr), err);
    endtask

    // ==========================================================
    // directed tests
    // ==========================================================

    task automatic test_single_port();
        data_t wdata;
        int    cycles;
        wdata = rand_word();
        apb_write(0, 12'h010, wdata, "single_port write");
        apb_read(0, 12'h010, "single_port read", cycles);
        check_count("single_port latency", UNLOADED_CYCLES, cycles);
    endtask

    // every port fills its own block and a neighbour reads it back
    task automatic test_cross_port();
        int cycles;
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int i = 0; i < 4; i++) begin
                apb_write(p, addr_t'(16 * (p + 2) + i), rand_word(), "cross_port write");
            end
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int i = 0; i < 4; i++) begin
                apb_read((p + 1) % NUM_PORTS, addr_t'(16 * (p + 2) + i),
                         "cross_port read", cycles);
            end
        end
    endtask

    task automatic test_simultaneous();
        data_t d [NUM_PORTS];
        for (int p = 0; p < NUM_PORTS; p++) begin
            d[p] = rand_word();
        end
        // the mask is empty after reset so the lowest index goes first and the
        // turn then moves upward
        apply_reset();
        done_order.delete();
        fork
            apb_write(0, 12'h080, d[0], "simultaneous write");
            apb_write(1, 12'h081, d[1], "simultaneous write");
            apb_write(2, 12'h082, d[2], "simultaneous write");
        join
        check_count("simultaneous count", NUM_PORTS, done_order.size());
        for (int i = 0; i < NUM_PORTS; i++) begin
            check_count("simultaneous order", i, done_order[i]);
        end
    endtask

    task automatic test_fairness();
        data_t d0 [3];
        data_t d1 [3];
        data_t d2;
        int    cycles;
        int    pos_2;
        int    pos_0b;
        int    pos_1b;
        int    seen_0;
        int    seen_1;
        for (int i = 0; i < 3; i++) begin
            d0[i] = rand_word();
            d1[i] = rand_word();
        end
        d2 = rand_word();
        done_order.delete();
        fork
            begin
                for (int i = 0; i < 3; i++) begin
                    apb_write(0, addr_t'(12'h0a0 + i), d0[i], "fairness write");
                end
            end
            begin
                for (int i = 0; i < 3; i++) begin
                    apb_write(1, addr_t'(12'h0b0 + i), d1[i], "fairness write");
                end
            end
            apb_write(2, 12'h0c0, d2, "fairness write");
        join
        pos_2  = -1;
        pos_0b = -1;
        pos_1b = -1;
        seen_0 = 0;
        seen_1 = 0;
        for (int i = 0; i < done_order.size(); i++) begin
            if (done_order[i] == 0) begin
                seen_0++;
                if (seen_0 == 2) begin
                    pos_0b = i;
                end
            end else if (done_order[i] == 1) begin
                seen_1++;
                if (seen_1 == 2) begin
                    pos_1b = i;
                end
            end else begin
                pos_2 = i;
            end
        end
        // port 2 must get its turn before either busy port is served twice
        if (pos_2 < 0 || pos_2 > pos_0b || pos_2 > pos_1b) begin
            $display("port 2 was not served before the second access of port 0 or 1");
            abort_run();
        end
        apb_read(0, 12'h0c0, "fairness read", cycles);
    endtask

    task automatic test_out_of_range();
        data_t keep;
        int    cycles;
        keep = rand_word();
        apb_write(1, 12'h005, keep, "range base write");
        // 12'h105 shares its low index bits with word 5
        apb_write(1, 12'h105, ~keep, "range write");
        apb_read(2, 12'h105, "range read", cycles);
        apb_read(2, 12'hfff, "range read top", cycles);
        apb_read(0, 12'h005, "range alias read", cycles);
    endtask

    // ==========================================================
    // main sequence
    // ==========================================================

    initial begin
        seed  = 32'h92c4;
        clk   = 1'b0;
        rst_n = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            psel[p]    = 1'b0;
            penable[p] = 1'b0;
            pwrite[p]  = 1'b0;
            paddr[p]   = '0;
            pwdata[p]  = '0;
        end
        apply_reset();
        test_single_port();
        test_cross_port();
        test_simultaneous();
        test_fairness();
        test_out_of_range();
        if (DUT.u_arbiter.u_arb_sva.fail_count == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("arbiter assertions failed %0d times",
                     DUT.u_arbiter.u_arb_sva.fail_count);
            abort_run();
        end
    end

endmodule : tb_top

`default_nettype wire
